// ==== rtl/digit_font.svh ====
/* 8x8 glyphs for the digits 0 to 9, MSB is the leftmost pixel;
   included inside the renderer module body */
`ifndef DIGIT_FONT_SVH
`define DIGIT_FONT_SVH

localparam logic [7:0] DIGIT_FONT [0:9][0:7] = '{
    '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
    '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
    '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
};

`endif

// ==== rtl/dino_pkg.sv ====
/* Game constants, obstacle geometry, bus register map and score type
   shared by the game logic, the renderer and the testbench */
package dino_pkg;

    typedef logic [10:0] pos_t;
    typedef logic [19:0] bcd_score_t;
    typedef logic [10:0] speed_t;

    localparam int N_DIGITS    = 5;
    localparam int N_OBSTACLES = 4;

    localparam int SCAC_START  = 1200;
    localparam int GROUP_START = 1600;
    localparam int LAVA_START  = 1800;
    localparam int PTERO_START = 1400;

    localparam int DINO_START_X = 100;
    localparam int GROUND_Y     = 248;
    localparam int PTERO_Y      = 200;

    localparam int SPRITE_H = 32;
    localparam int DINO_W   = 32;
    localparam int NARROW_W = 32;
    localparam int GROUP_W  = 64;

    localparam int PASSES_PER_SPEEDUP = 12;
    localparam logic [5:0] LFSR_SEED = 6'b101011;

    // Writes at 0, 1 and 19, reads from 32 up
    localparam logic [8:0] REG_DINO_X  = 9'd0;
    localparam logic [8:0] REG_DINO_Y  = 9'd1;
    localparam logic [8:0] REG_REPLAY  = 9'd19;
    localparam logic [8:0] REG_STATUS  = 9'd32;
    localparam logic [8:0] REG_SCORE   = 9'd33;
    localparam logic [8:0] REG_OBST_X0 = 9'd34;
    localparam logic [8:0] REG_OBST_X1 = 9'd35;
    localparam logic [8:0] REG_OBST_X2 = 9'd36;
    localparam logic [8:0] REG_OBST_X3 = 9'd37;

    localparam int SCORE_X       = 120;
    localparam int SCORE_Y       = 10;
    localparam int REPLAY_X      = 560;
    localparam int REPLAY_Y      = 200;
    localparam int REPLAY_W      = 160;
    localparam int GROUND_LINE   = 280;
    localparam int GROUND_STRIPE = 300;

endpackage

// ==== rtl/dino_run_top.sv ====
/* Top level of the runner game: bus slave in, VGA pins out;
   MOVE_PERIOD sets how many clocks pass between motion steps */
module dino_run_top #(
    parameter int MOVE_PERIOD = 2_000_000
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          chipselect,
    input  logic          write,
    input  logic          read,
    input  logic [8:0]    address,
    input  logic [31:0]   writedata,
    output logic [31:0]   readdata,
    output vga_pkg::rgb_t vga_r,
    output vga_pkg::rgb_t vga_g,
    output vga_pkg::rgb_t vga_b,
    output logic          vga_clk,
    output logic          vga_hs,
    output logic          vga_vs,
    output logic          vga_blank_n,
    output logic          vga_sync_n
);
    import vga_pkg::*;
    import dino_pkg::*;

    // Small cactus, cactus group, lava, pterodactyl
    localparam int OBST_START [N_OBSTACLES] = '{SCAC_START, GROUP_START, LAVA_START, PTERO_START};
    localparam int OBST_W [N_OBSTACLES]     = '{NARROW_W, GROUP_W, NARROW_W, NARROW_W};
    localparam int OBST_Y [N_OBSTACLES]     = '{GROUND_Y, GROUND_Y, GROUND_Y, PTERO_Y};

    hcoord_t                hcount;
    vcoord_t                vcount;
    logic                   line_end;
    logic                   tick;
    logic [5:0]             lfsr;
    logic                   game_over;
    logic                   restart;
    speed_t                 speed;
    pos_t                   dino_x;
    pos_t                   dino_y;
    pos_t                   obst_x [N_OBSTACLES];
    logic [N_OBSTACLES-1:0] passed;
    logic [N_OBSTACLES-1:0] hit;
    bcd_score_t             score;

    vga_timing u_timing (
        .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
        .line_end(line_end), .vga_clk(vga_clk), .vga_hs(vga_hs), .vga_vs(vga_vs),
        .vga_blank_n(vga_blank_n), .vga_sync_n(vga_sync_n)
    );

    motion_pacer #(.MOVE_PERIOD(MOVE_PERIOD)) u_pacer (
        .clk(clk), .reset(reset), .game_over(game_over), .tick(tick), .lfsr(lfsr)
    );

    for (genvar i = 0; i < N_OBSTACLES; i++) begin : g_obst
        obstacle_track #(
            .START_X(OBST_START[i]), .WIDTH(OBST_W[i]), .Y(OBST_Y[i]), .RESPAWN_SEL(i)
        ) u_track (
            .clk(clk), .reset(reset), .tick(tick), .restart(restart),
            .game_over(game_over), .speed(speed), .lfsr(lfsr), .dino_x(dino_x),
            .dino_y(dino_y), .obst_x(obst_x[i]), .passed(passed[i]), .hit(hit[i])
        );
    end

    score_counter u_score (
        .clk(clk), .reset(reset), .tick(tick), .restart(restart),
        .game_over(game_over), .score(score)
    );

    game_state u_state (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write), .read(read),
        .tick(tick), .address(address), .writedata(writedata), .passed(passed),
        .hit(hit), .score(score), .obst_x0(obst_x[0]), .obst_x1(obst_x[1]),
        .obst_x2(obst_x[2]), .obst_x3(obst_x[3]), .game_over(game_over),
        .restart(restart), .speed(speed), .dino_x(dino_x), .dino_y(dino_y),
        .readdata(readdata)
    );

    pixel_renderer u_render (
        .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
        .line_end(line_end), .game_over(game_over), .dino_x(dino_x), .dino_y(dino_y),
        .obst_x0(obst_x[0]), .obst_x1(obst_x[1]), .obst_x2(obst_x[2]),
        .obst_x3(obst_x[3]), .score(score), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
    );

endmodule

// ==== rtl/game_state.sv ====
/* Bus register block and game control: dino position, speed-up after
   passes, game over on a hit, replay restart and the status read mux */
module game_state (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 chipselect,
    input  logic                 write,
    input  logic                 read,
    input  logic                 tick,
    input  logic [8:0]           address,
    input  logic [31:0]          writedata,
    input  logic [3:0]           passed,
    input  logic [3:0]           hit,
    input  dino_pkg::bcd_score_t score,
    input  dino_pkg::pos_t       obst_x0,
    input  dino_pkg::pos_t       obst_x1,
    input  dino_pkg::pos_t       obst_x2,
    input  dino_pkg::pos_t       obst_x3,
    output logic                 game_over,
    output logic                 restart,
    output dino_pkg::speed_t     speed,
    output dino_pkg::pos_t       dino_x,
    output dino_pkg::pos_t       dino_y,
    output logic [31:0]          readdata
);
    import dino_pkg::*;

    logic [4:0] pass_cnt;
    logic       wr_en;

    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dino_x <= pos_t'(DINO_START_X);
            dino_y <= pos_t'(GROUND_Y);
        end else if (wr_en && address == REG_DINO_X) begin
            dino_x <= writedata[10:0];
        end else if (wr_en && address == REG_DINO_Y) begin
            dino_y <= writedata[10:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            restart   <= 1'b0;
            game_over <= 1'b0;
            speed     <= speed_t'(1);
            pass_cnt  <= '0;
        end else begin
            // Replay only counts once the game has ended
            restart <= wr_en && address == REG_REPLAY && game_over && !restart;
            if (restart) begin
                game_over <= 1'b0;
                speed     <= speed_t'(1);
                pass_cnt  <= '0;
            end else begin
                if (|hit) begin
                    game_over <= 1'b1;
                end
                if (tick && pass_cnt >= 5'(PASSES_PER_SPEEDUP)) begin
                    speed    <= speed + 1'b1;
                    pass_cnt <= '0;
                end else if (tick) begin
                    pass_cnt <= pass_cnt + 5'($countones(passed));
                end
            end
        end
    end

    always_comb begin
        readdata = '0;
        if (chipselect && read) begin
            case (address)
                REG_STATUS:  readdata = {31'd0, game_over};
                REG_SCORE:   readdata = {12'd0, score};
                REG_OBST_X0: readdata = {21'd0, obst_x0};
                REG_OBST_X1: readdata = {21'd0, obst_x1};
                REG_OBST_X2: readdata = {21'd0, obst_x2};
                REG_OBST_X3: readdata = {21'd0, obst_x3};
                default:     readdata = '0;
            endcase
        end
    end

    a_restart_in_game_over: assert property (@(posedge clk) disable iff (reset)
        restart |-> game_over);

endmodule

// ==== rtl/motion_pacer.sv ====
/* Motion tick divider and obstacle respawn LFSR; both stop while the
   game is over */
module motion_pacer #(
    parameter int MOVE_PERIOD = 2_000_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       game_over,
    output logic       tick,
    output logic [5:0] lfsr
);
    import dino_pkg::*;

    localparam int CNT_W = $clog2(MOVE_PERIOD);

    logic [CNT_W-1:0] count;

    assign tick = !game_over && (count == CNT_W'(MOVE_PERIOD - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else if (!game_over) begin
            count <= count + 1'b1;
        end
    end

    // x^6 + x^5 + 1, stepped once per tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (tick) begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
        end
    end

    a_lfsr_nonzero: assert property (@(posedge clk) disable iff (reset)
        lfsr != 6'd0);

endmodule

// ==== rtl/obstacle_track.sv ====
/* One obstacle: horizontal position, leftward motion, respawn past the
   right edge and box overlap with the dino */
module obstacle_track #(
    parameter int START_X     = 1200,
    parameter int WIDTH       = 32,
    parameter int Y           = 248,
    parameter int RESPAWN_SEL = 0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            tick,
    input  logic            restart,
    input  logic            game_over,
    input  dino_pkg::speed_t speed,
    input  logic [5:0]      lfsr,
    input  dino_pkg::pos_t  dino_x,
    input  dino_pkg::pos_t  dino_y,
    output dino_pkg::pos_t  obst_x,
    output logic            passed,
    output logic            hit
);
    import vga_pkg::*;
    import dino_pkg::*;

    logic [9:0] offset;
    logic       step;

    // Each instance takes a different slice so respawns spread out
    always_comb begin
        case (RESPAWN_SEL)
            1:       offset = {~lfsr, 4'd0};
            2:       offset = {lfsr[3:0], 6'd0};
            3:       offset = {lfsr[5:2], 6'd0};
            default: offset = {lfsr, 4'd0};
        endcase
    end

    assign step   = tick && !game_over;
    assign passed = step && (obst_x <= speed);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            obst_x <= pos_t'(START_X);
        end else if (restart) begin
            obst_x <= pos_t'(START_X);
        end else if (passed) begin
            obst_x <= pos_t'(H_ACTIVE) + pos_t'(offset);
        end else if (step) begin
            obst_x <= obst_x - speed;
        end
    end

    // Sums kept at 12 bits so a respawned x near 2047 does not wrap
    assign hit = ({1'b0, dino_x} < {1'b0, obst_x} + 12'(WIDTH)) &&
                 ({1'b0, dino_x} + 12'(DINO_W) > {1'b0, obst_x}) &&
                 ({1'b0, dino_y} < 12'(Y + SPRITE_H)) &&
                 ({1'b0, dino_y} + 12'(SPRITE_H) > 12'(Y));

endmodule

// ==== rtl/pixel_renderer.sv ====
/* Per-pixel colour for the current raster position; the colour reaches
   the DAC one clock after hcount and vcount */
module pixel_renderer (
    input  logic                 clk,
    input  logic                 reset,
    input  vga_pkg::hcoord_t     hcount,
    input  vga_pkg::vcoord_t     vcount,
    input  logic                 line_end,
    input  logic                 game_over,
    input  dino_pkg::pos_t       dino_x,
    input  dino_pkg::pos_t       dino_y,
    input  dino_pkg::pos_t       obst_x0,
    input  dino_pkg::pos_t       obst_x1,
    input  dino_pkg::pos_t       obst_x2,
    input  dino_pkg::pos_t       obst_x3,
    input  dino_pkg::bcd_score_t score,
    output vga_pkg::rgb_t        vga_r,
    output vga_pkg::rgb_t        vga_g,
    output vga_pkg::rgb_t        vga_b
);
    import vga_pkg::*;
    import dino_pkg::*;

    `include "digit_font.svh"

    localparam logic [23:0] SKY    = {8'd135, 8'd206, 8'd235};
    localparam logic [23:0] GROUND = {8'd139, 8'd69, 8'd19};
    localparam logic [23:0] STRIPE = {8'd100, 8'd40, 8'd10};
    localparam logic [23:0] BLACK  = 24'h000000;
    localparam logic [23:0] WHITE  = 24'hFFFFFF;
    localparam logic [23:0] SCAC   = {8'd0, 8'd160, 8'd0};
    localparam logic [23:0] GROUP  = {8'd0, 8'd120, 8'd0};
    localparam logic [23:0] LAVA   = {8'd255, 8'd64, 8'd0};
    localparam logic [23:0] PTERO  = {8'd96, 8'd96, 8'd96};
    localparam logic [23:0] DINO   = {8'd64, 8'd64, 8'd64};

    bcd_score_t  score_q;
    logic [23:0] colour;
    hcoord_t     glyph_col;
    vcoord_t     glyph_row;
    logic [3:0]  digit;

    function automatic logic in_box(input logic [11:0] px, py, x, y, w, h);
        return (px >= x) && (px < x + w) && (py >= y) && (py < y + h);
    endfunction

    // Score sampled once per line so a digit never changes mid-glyph
    always_ff @(posedge clk) begin
        if (line_end) begin
            score_q <= score;
        end
    end

    assign glyph_col = hcount - hcoord_t'(SCORE_X);
    assign glyph_row = vcount - vcoord_t'(SCORE_Y);
    assign digit     = score_q[4*(N_DIGITS - 1 - glyph_col[5:3]) +: 4];

    always_comb begin
        if (vcount < GROUND_LINE) begin
            colour = SKY;
        end else if (vcount > GROUND_STRIPE) begin
            colour = STRIPE;
        end else begin
            colour = GROUND;
        end

        if (game_over) begin
            if (in_box(12'(hcount), 12'(vcount), 12'(REPLAY_X), 12'(REPLAY_Y),
                       12'(REPLAY_W), 12'(SPRITE_H))) begin
                colour = WHITE;
            end
        end else begin
            if (vcount == GROUND_LINE) begin
                colour = BLACK;
            end
            // Later boxes cover earlier ones
            if (in_box(12'(hcount), 12'(vcount), 12'(obst_x0), 12'(GROUND_Y),
                       12'(NARROW_W), 12'(SPRITE_H))) colour = SCAC;
            if (in_box(12'(hcount), 12'(vcount), 12'(obst_x1), 12'(GROUND_Y),
                       12'(GROUP_W), 12'(SPRITE_H))) colour = GROUP;
            if (in_box(12'(hcount), 12'(vcount), 12'(obst_x2), 12'(GROUND_Y),
                       12'(NARROW_W), 12'(SPRITE_H))) colour = LAVA;
            if (in_box(12'(hcount), 12'(vcount), 12'(obst_x3), 12'(PTERO_Y),
                       12'(NARROW_W), 12'(SPRITE_H))) colour = PTERO;
            if (in_box(12'(hcount), 12'(vcount), 12'(dino_x), 12'(dino_y),
                       12'(DINO_W), 12'(SPRITE_H))) colour = DINO;
            if (in_box(12'(hcount), 12'(vcount), 12'(SCORE_X), 12'(SCORE_Y),
                       12'(N_DIGITS * 8), 12'd8) &&
                DIGIT_FONT[digit][glyph_row[2:0]][3'd7 - glyph_col[2:0]]) begin
                colour = BLACK;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            {vga_r, vga_g, vga_b} <= colour;
        end
    end

endmodule

// ==== rtl/score_counter.sv ====
/* Five-digit BCD score, one count per motion tick, wrapping after 99999 */
module score_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  logic                 restart,
    input  logic                 game_over,
    output dino_pkg::bcd_score_t score
);
    import dino_pkg::*;

    bcd_score_t next_score;
    logic       carry;

    // Ripple the increment up through the digits
    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < N_DIGITS; i++) begin
            if (carry && score[4*i +: 4] == 4'd9) begin
                next_score[4*i +: 4] = 4'd0;
            end else begin
                next_score[4*i +: 4] = score[4*i +: 4] + {3'd0, carry};
                carry = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (restart) begin
            score <= '0;
        end else if (tick && !game_over) begin
            score <= next_score;
        end
    end

    for (genvar d = 0; d < N_DIGITS; d++) begin : g_digit_chk
        a_digit_bcd: assert property (@(posedge clk) disable iff (reset)
            score[4*d +: 4] <= 4'd9);
    end

endmodule

// ==== rtl/vga_pkg.sv ====
/* Raster timing and pixel types for the 1280x480 VGA output,
   imported by the timing generator, the renderer and the game blocks */
package vga_pkg;

    typedef logic [10:0] hcoord_t;
    typedef logic [9:0]  vcoord_t;
    typedef logic [7:0]  rgb_t;

    // Horizontal timing in clocks
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = 1600;

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = 525;

endpackage

// ==== rtl/vga_timing.sv ====
/* Pixel and line counters with sync and blank decode for the VGA DAC */
module vga_timing (
    input  logic             clk,
    input  logic             reset,
    output vga_pkg::hcoord_t hcount,
    output vga_pkg::vcoord_t vcount,
    output logic             line_end,
    output logic             vga_clk,
    output logic             vga_hs,
    output logic             vga_vs,
    output logic             vga_blank_n,
    output logic             vga_sync_n
);
    import vga_pkg::*;

    logic frame_end;

    assign line_end  = (hcount == hcoord_t'(H_TOTAL - 1));
    assign frame_end = (vcount == vcoord_t'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            vcount <= frame_end ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Sync pulses are active low
    assign vga_hs = !((hcount >= H_ACTIVE + H_FRONT) &&
                      (hcount <  H_ACTIVE + H_FRONT + H_SYNC));
    assign vga_vs = !((vcount >= V_ACTIVE + V_FRONT) &&
                      (vcount <  V_ACTIVE + V_FRONT + V_SYNC));

    assign vga_blank_n = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    assign vga_sync_n  = 1'b0;
    assign vga_clk     = hcount[0];

    a_hcount_range: assert property (@(posedge clk) disable iff (reset)
        hcount < H_TOTAL);

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/vga_pkg.sv
rtl/dino_pkg.sv
rtl/vga_timing.sv
rtl/motion_pacer.sv
rtl/obstacle_track.sv
rtl/score_counter.sv
rtl/game_state.sv
rtl/pixel_renderer.sv
rtl/dino_run_top.sv
verification/dino_run_tb.sv

// ==== verification/dino_run_tb.sv ====
/* Testbench for the runner game core: bus reads checked against a reference
   model of the game rules, then VGA sync timing and sample pixels */
module dino_run_tb;
    import vga_pkg::*;
    import dino_pkg::*;

    localparam int MOVE_PERIOD = 64;
    localparam int FRAME       = V_TOTAL * H_TOTAL;
    localparam int PIN_HS      = 0;
    localparam int PIN_VS      = 1;
    localparam int PIN_BLANK   = 2;

    logic        clk = 1'b0;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic        read;
    logic [8:0]  address;
    logic [31:0] writedata;
    logic [31:0] readdata;
    rgb_t        vga_r;
    rgb_t        vga_g;
    rgb_t        vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;

    // Reference model state
    pos_t       m_x [N_OBSTACLES];
    speed_t     m_speed;
    int         m_pass;
    logic [5:0] m_lfsr;
    bcd_score_t m_score;
    int         m_respawns;
    int         m_ticks;

    // Values read from the DUT after one tick
    bcd_score_t obs_score;
    pos_t       obs_x [N_OBSTACLES];
    event       tick_seen;

    dino_run_top #(.MOVE_PERIOD(MOVE_PERIOD)) DUT (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write), .read(read),
        .address(address), .writedata(writedata), .readdata(readdata),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_clk(vga_clk),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
        .vga_sync_n(vga_sync_n)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic timeout_fail(input string why);
        $display("Error: %s", why);
        stop_run();
    endtask

    task automatic check_pos(input string name, input pos_t exp, input pos_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_score(input string name, input bcd_score_t exp,
                               input bcd_score_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %05h, actual %05h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    function automatic pos_t start_x(input int idx);
        case (idx)
            0:       return pos_t'(SCAC_START);
            1:       return pos_t'(GROUP_START);
            2:       return pos_t'(LAVA_START);
            default: return pos_t'(PTERO_START);
        endcase
    endfunction

    // Offset past the right edge, one LFSR slice per obstacle
    function automatic int respawn_offset(input int idx, input logic [5:0] r);
        logic [5:0] inv;
        inv = ~r;
        case (idx)
            0:       return int'(r) * 16;
            1:       return int'(inv) * 16;
            2:       return int'(r[3:0]) * 64;
            default: return int'(r[5:2]) * 64;
        endcase
    endfunction

    function automatic bcd_score_t bcd_increment(input bcd_score_t s);
        bcd_score_t r;
        int         d;
        int         carry;
        r = s;
        carry = 1;
        for (int i = 0; i < N_DIGITS; i++) begin
            d = int'(s[4*i +: 4]) + carry;
            if (d == 10) begin
                r[4*i +: 4] = 4'd0;
                carry = 1;
            end else begin
                r[4*i +: 4] = 4'(d);
                carry = 0;
            end
        end
        return r;
    endfunction

    // One motion tick of the game rules
    function automatic void advance_model();
        int passes;
        passes = 0;
        for (int i = 0; i < N_OBSTACLES; i++) begin
            if (m_x[i] <= m_speed) begin
                // 11-bit position, so a far respawn wraps
                m_x[i] = pos_t'(H_ACTIVE + respawn_offset(i, m_lfsr));
                passes++;
                m_respawns++;
            end else begin
                m_x[i] = m_x[i] - m_speed;
            end
        end
        if (m_pass >= PASSES_PER_SPEEDUP) begin
            m_speed = m_speed + 1'b1;
            m_pass = 0;
        end else begin
            m_pass = m_pass + passes;
        end
        m_lfsr = {m_lfsr[4:0], m_lfsr[5] ^ m_lfsr[4]};
        m_score = bcd_increment(m_score);
        m_ticks++;
    endfunction

    function automatic logic pin_value(input int which);
        case (which)
            PIN_HS:  return vga_hs;
            PIN_VS:  return vga_vs;
            default: return vga_blank_n;
        endcase
    endfunction

    function automatic string pin_name(input int which);
        case (which)
            PIN_HS:  return "vga_hs";
            PIN_VS:  return "vga_vs";
            default: return "vga_blank_n";
        endcase
    endfunction

    task automatic bus_read(input logic [8:0] addr, output logic [31:0] data);
        chipselect = 1'b1;
        read = 1'b1;
        write = 1'b0;
        address = addr;
        @(negedge clk);
        data = readdata;
    endtask

    task automatic bus_write(input logic [8:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        write = 1'b1;
        read = 1'b0;
        address = addr;
        writedata = data;
        @(negedge clk);
        write = 1'b0;
        chipselect = 1'b0;
    endtask

    // Returns just after the next motion tick, seen as a new score
    task automatic wait_score_change(output bcd_score_t now_score);
        logic [31:0] base;
        logic [31:0] data;
        int          waited;
        waited = 0;
        bus_read(REG_SCORE, base);
        data = base;
        while (data[19:0] == base[19:0]) begin
            if (waited >= 3 * MOVE_PERIOD) begin
                timeout_fail("score did not advance within three tick periods");
            end
            bus_read(REG_SCORE, data);
            waited++;
        end
        now_score = data[19:0];
    endtask

    task automatic wait_status(input logic level);
        logic [31:0] data;
        int          waited;
        waited = 0;
        bus_read(REG_STATUS, data);
        while (data[0] !== level) begin
            if (waited >= 16) begin
                timeout_fail("status bit 0 did not change within 16 cycles");
            end
            bus_read(REG_STATUS, data);
            waited++;
        end
    endtask

    task automatic wait_pin(input int which, input logic level, input int limit,
                            output int cycles);
        cycles = 0;
        while (pin_value(which) !== level) begin
            if (cycles >= limit) begin
                timeout_fail($sformatf("%s never went to %b", pin_name(which), level));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // The DAC clock runs at half the counter rate and composite sync stays low
    task automatic watch_dac_pins();
        logic prev;
        prev = vga_clk;
        for (int c = 0; c < H_TOTAL; c++) begin
            @(negedge clk);
            check_bit($sformatf("vga_clk toggle %0d", c), !prev, vga_clk);
            check_bit("vga_sync_n", 1'b0, vga_sync_n);
            prev = vga_clk;
        end
    endtask

    task automatic check_start_positions(input string name);
        logic [31:0] data;
        for (int i = 0; i < N_OBSTACLES; i++) begin
            bus_read(9'(REG_OBST_X0 + i), data);
            check_pos($sformatf("%s obstacle %0d", name, i), start_x(i), data[10:0]);
        end
    endtask

    // Puts the dino on the small cactus right after a tick
    task automatic force_collision();
        bcd_score_t  s;
        logic [31:0] data;
        wait_score_change(s);
        bus_read(REG_OBST_X0, data);
        bus_write(REG_DINO_X, data);
        bus_write(REG_DINO_Y, GROUND_Y);
        wait_status(1'b1);
    endtask

    // Colour of raster position (h, v), one clock after that position
    task automatic sample_pixel(input int h, input int v, output rgb_t r, output rgb_t g,
                                output rgb_t b);
        int n;
        wait_pin(PIN_VS, 1'b0, 2 * FRAME, n);
        wait_pin(PIN_VS, 1'b1, 4 * H_TOTAL, n);
        // Counters are at the first back porch line, column 0
        repeat ((V_BACK + v) * H_TOTAL + h + 1) @(negedge clk);
        r = vga_r;
        g = vga_g;
        b = vga_b;
    endtask

    task automatic check_pixel(input string name, input rgb_t er, input rgb_t eg,
                               input rgb_t eb, input int h, input int v);
        rgb_t r;
        rgb_t g;
        rgb_t b;
        sample_pixel(h, v, r, g, b);
        check_rgb({name, " red"}, er, r);
        check_rgb({name, " green"}, eg, g);
        check_rgb({name, " blue"}, eb, b);
    endtask

    always @(tick_seen) begin
        advance_model();
        check_score($sformatf("tick %0d score", m_ticks), m_score, obs_score);
        for (int i = 0; i < N_OBSTACLES; i++) begin
            check_pos($sformatf("tick %0d obstacle %0d", m_ticks, i), m_x[i], obs_x[i]);
        end
    end

    initial begin
        logic [31:0] data;
        bcd_score_t  s;
        int          ticks;
        int          extra;
        int          n_low;
        int          n_high;

        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        read = 1'b0;
        address = '0;
        writedata = '0;
        for (int i = 0; i < N_OBSTACLES; i++) begin
            m_x[i] = start_x(i);
        end
        m_speed = speed_t'(1);
        m_pass = 0;
        m_lfsr = LFSR_SEED;
        m_score = '0;
        m_respawns = 0;
        m_ticks = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // State right after reset, well before the first tick
        bus_read(REG_STATUS, data);
        check_bit("reset status", 1'b0, data[0]);
        bus_read(REG_SCORE, data);
        check_score("reset score", '0, data[19:0]);
        check_start_positions("reset");

        // Dino out of reach of every obstacle, then follow the model tick by tick
        bus_write(REG_DINO_Y, 32'd0);
        ticks = 0;
        extra = 0;
        while (extra < 16) begin
            if (ticks >= 12000) begin
                timeout_fail("no speed-up within 12000 motion ticks");
            end
            wait_score_change(obs_score);
            for (int i = 0; i < N_OBSTACLES; i++) begin
                bus_read(9'(REG_OBST_X0 + i), data);
                obs_x[i] = data[10:0];
            end
            -> tick_seen;
            @(negedge clk);
            ticks++;
            if (m_speed > 1 && m_respawns > 0) begin
                extra++;
            end
        end

        // Collision one tick later ends the game and freezes the score
        force_collision();
        bus_read(REG_STATUS, data);
        check_bit("status after collision", 1'b1, data[0]);
        s = bcd_increment(m_score);
        for (int c = 0; c < 4 * MOVE_PERIOD; c++) begin
            bus_read(REG_SCORE, data);
            check_score("score frozen", s, data[19:0]);
        end

        // Replay
        bus_write(REG_DINO_Y, 32'd0);
        bus_write(REG_REPLAY, 32'd1);
        wait_status(1'b0);
        bus_read(REG_SCORE, data);
        check_score("score after replay", '0, data[19:0]);
        check_start_positions("replay");
        wait_score_change(s);
        check_score("first score after replay", 20'h00001, s);

        // Sync pulses, blanking and DAC pins
        wait_pin(PIN_HS, 1'b1, 2 * H_TOTAL, n_low);
        wait_pin(PIN_HS, 1'b0, 2 * H_TOTAL, n_low);
        wait_pin(PIN_HS, 1'b1, 2 * H_TOTAL, n_low);
        wait_pin(PIN_HS, 1'b0, 2 * H_TOTAL, n_high);
        check_count("hsync low length", H_SYNC, n_low);
        check_count("hsync period", H_TOTAL, n_low + n_high);
        wait_pin(PIN_BLANK, 1'b0, 2 * FRAME, n_low);
        wait_pin(PIN_BLANK, 1'b1, 2 * FRAME, n_low);
        wait_pin(PIN_BLANK, 1'b0, 2 * H_TOTAL, n_high);
        check_count("blank_n high per line", H_ACTIVE, n_high);
        wait_pin(PIN_VS, 1'b1, 2 * FRAME, n_low);
        wait_pin(PIN_VS, 1'b0, 2 * FRAME, n_low);
        wait_pin(PIN_VS, 1'b1, 4 * H_TOTAL, n_low);
        check_count("vsync low length", V_SYNC * H_TOTAL, n_low);
        watch_dac_pins();

        // Pixels during play, then the replay box after game over
        check_pixel("sky pixel", 8'd135, 8'd206, 8'd235, 640, 100);
        check_pixel("ground line pixel", 8'd0, 8'd0, 8'd0, 640, GROUND_LINE);
        force_collision();
        check_pixel("replay box pixel", 8'd255, 8'd255, 8'd255, 600, 210);

        $display("All tests passed!");
        $finish;
    end

endmodule
